/* dv/dec_input_vectors.txt */
# len nibbles start_pc class op flags imm, all hex, nibbles in issue order
# flags bits 7..0 are push pop set_xm set_carry test_carry carry_val en_intr mode_dec
02 00 00100 0 0 60 0000000000000000
02 01 00102 0 0 40 0000000000000000
02 02 00104 0 0 54 0000000000000000
02 03 00106 0 0 50 0000000000000000
02 0F 00108 0 0 42 0000000000000000
02 04 0010A 1 0 00 0000000000000000
02 05 0010C 1 0 01 0000000000000000
02 06 0010E 2 1 80 0000000000000000
02 07 00110 2 1 40 0000000000000000
02 08 00112 2 3 00 0000000000000000
02 09 00114 2 1 00 0000000000000000
02 0A 00116 2 1 00 0000000000000000
02 0B 00118 2 2 00 0000000000000000
02 0C 0011A 2 4 00 0000000000000000
02 0D 0011C 2 5 00 0000000000000000
02 27 0011E 3 1 00 0000000000000007
03 305 00120 4 1 00 0000000000000005
06 3312AB 00123 4 1 00 000000000000BA21
12 3F0123456789ABCDEF 00129 4 1 00 FEDCBA9876543210
03 412 0013B 5 6 0C 0000000000000021
03 5A7 0013E 5 6 08 000000000000007A
04 6123 00141 5 7 00 0000000000000321
04 7FE0 00145 5 7 80 00000000000000EF
01 1 00149 6 0 00 0000000000000000
02 2F 0014A 3 1 00 000000000000000F
01 8 0014C 6 0 00 0000000000000000
01 9 0014D 6 0 00 0000000000000000
01 A 0014E 6 0 00 0000000000000000
01 B 0014F 6 0 00 0000000000000000
01 C 00150 6 0 00 0000000000000000
01 D 00151 6 0 00 0000000000000000
01 E 00152 6 0 00 0000000000000000
01 F 00153 6 0 00 0000000000000000
02 0E 00154 6 0 00 0000000000000000
02 01 00156 0 0 40 0000000000000000

/* dv/tb_clock_gen.sv */
// testbench clock source
`timescale 1ns/100ps

module tb_clock_gen (
  output logic o_clk
);

  // 8 ns period
  initial begin
    o_clk = 1'b0;
    forever begin
      #4 o_clk = ~o_clk;
    end
  end

endmodule

/* dv/tb_saturn_dec.sv */
// decoder testbench
`timescale 1ns/100ps

module tb_saturn_dec
  import saturn_dec_pkg::*;
();

  localparam int    MAX_VEC  = 64;
  localparam string VEC_FILE = "dv/dec_input_vectors.txt";

  logic        clk;
  logic        reset;
  logic        en_dec;
  logic        stall;
  nib_in_t     nib;
  ins_rec_t    ins;
  logic        ins_valid;

  ins_rec_t    exp_recs [MAX_VEC];
  logic [71:0] vec_nibs [MAX_VEC];
  int          vec_len [MAX_VEC];
  int          num_vec = 0;
  int          total_nibs = 0;
  int          rec_count = 0;
  int          errors = 0;
  int          cycle_count = 0;
  int          timeout_limit = 0;
  logic [31:0] rnd_state = 32'd68;
  bit          load_ok;
  bit          timed_out;

  tb_clock_gen tb_clock_gen_inst (
    .o_clk (clk)
  );

  saturn_dec_top saturn_dec_top_inst (
    .i_clk       (clk),
    .i_reset     (reset),
    .i_en_dec    (en_dec),
    .i_stall     (stall),
    .i_nib       (nib),
    .o_ins       (ins),
    .o_ins_valid (ins_valid)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: record %0d %s is %0h, expected %0h",
               $time, rec_count, what, got, exp);
    end
  endtask

  // one line per instruction, lines starting with # are skipped
  task automatic load_vectors(output bit ok);
    int          fd;
    int          fields;
    string       line;
    logic [31:0] len_v;
    logic [71:0] nibs_v;
    logic [31:0] pc_v;
    logic [31:0] cls_v;
    logic [31:0] op_v;
    logic [31:0] flags_v;
    logic [63:0] imm_v;
    ins_rec_t    rec;
    fd = $fopen(VEC_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd) && num_vec < MAX_VEC) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h", len_v, nibs_v, pc_v,
                           cls_v, op_v, flags_v, imm_v);
          if (fields == 7) begin
            rec.addr          = pc_v[ADDR_W-1:0];
            rec.ins_class     = ins_class_e'(cls_v[2:0]);
            rec.alu_op        = alu_op_e'(op_v[3:0]);
            rec.flags         = dec_flags_t'(flags_v[7:0]);
            rec.imm           = imm_v;
            rec.nib_cnt       = len_v[LEN_W-1:0];
            exp_recs[num_vec] = rec;
            vec_nibs[num_vec] = nibs_v;
            vec_len[num_vec]  = int'(len_v);
            total_nibs        = total_nibs + int'(len_v);
            num_vec++;
          end
        end
      end
      $fclose(fd);
    end
    // reset cycles plus six cycles per nibble and some slack
    timeout_limit = 8 + 6 * total_nibs + 200;
    ok = (num_vec > 0);
  endtask

  // random en gaps and stalls, junk nibble while not consumed
  task automatic drive_nibble(input logic [ADDR_W-1:0] addr,
                              input logic [NIB_W-1:0] value);
    logic en;
    logic hold;
    en   = 1'b0;
    hold = 1'b1;
    while (!en || hold) begin
      @(posedge clk);
      rnd_state = xorshift32(rnd_state);
      en        = (rnd_state[2:0] != 3'd0);
      hold      = (rnd_state[5:3] == 3'd0);
      en_dec <= en;
      stall  <= hold;
      nib    <= (en && !hold) ? {addr, value} : {addr, rnd_state[11:8]};
    end
  endtask

  task automatic run_vectors();
    logic [ADDR_W-1:0] addr;
    addr = exp_recs[0].addr;
    for (int v = 0; v < num_vec; v++) begin
      for (int k = 0; k < vec_len[v]; k++) begin
        drive_nibble(addr, vec_nibs[v][4 * (vec_len[v] - 1 - k) +: 4]);
        addr = addr + 1'b1;
      end
    end
    @(posedge clk);
    en_dec <= 1'b0;
    stall  <= 1'b0;
  endtask

  // records are matched in order, a pulse held too long finds the wrong one
  always @(posedge clk) begin
    cycle_count++;
    if (!reset && ins_valid) begin
      if (rec_count >= num_vec) begin
        errors++;
        $display("record at %0t arrived with no instruction left to match it", $time);
      end else begin
        check_value("addr", 64'(ins.addr), 64'(exp_recs[rec_count].addr));
        check_value("class", 64'(ins.ins_class), 64'(exp_recs[rec_count].ins_class));
        check_value("alu_op", 64'(ins.alu_op), 64'(exp_recs[rec_count].alu_op));
        check_value("flags", 64'(ins.flags), 64'(exp_recs[rec_count].flags));
        check_value("imm", ins.imm, exp_recs[rec_count].imm);
        check_value("nib_cnt", 64'(ins.nib_cnt), 64'(exp_recs[rec_count].nib_cnt));
        rec_count++;
      end
    end
  end

  initial begin
    reset  <= 1'b1;
    en_dec <= 1'b0;
    stall  <= 1'b0;
    nib    <= '0;
    load_vectors(load_ok);
    if (!load_ok) begin
      $display("no vectors could be read from %s", VEC_FILE);
      $display("Simulation failed");
      $finish;
    end else begin
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      run_vectors();
      while (rec_count < num_vec && cycle_count < timeout_limit) begin
        @(posedge clk);
      end
      // a few idle cycles to catch stray pulses
      repeat (4) @(posedge clk);
      timed_out = (rec_count < num_vec);
      if (timed_out) begin
        $display("timeout after %0d cycles, not every record arrived", cycle_count);
      end
      $display("records %0d of %0d, errors %0d, timeouts %0d",
               rec_count, num_vec, errors, timed_out);
      if (errors == 0 && !timed_out) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

/* hw/block0_decode.sv */
// 0x block decoder
`timescale 1ns/100ps

module block0_decode
  import saturn_dec_pkg::*;
(
  input  logic [NIB_W-1:0] i_nibble,
  output ins_class_e       o_class,
  output alu_op_e          o_op,
  output dec_flags_t       o_flags
);

  always_comb begin
    o_class = ALU;
    o_op    = NONE;
    o_flags = '0;

    case (i_nibble)
      4'h0, 4'h1, 4'h2, 4'h3, 4'hF: begin
        // RTNSXM RTN RTNSC RTNCC RTI
        o_class           = RTN;
        o_flags.pop       = 1'b1;
        o_flags.set_xm    = (i_nibble == 4'h0);
        o_flags.set_carry = !i_nibble[3] && i_nibble[1];
        o_flags.carry_val = !i_nibble[3] && i_nibble[1] && !i_nibble[0];
        o_flags.en_intr   = i_nibble[3];
      end
      4'h4, 4'h5: begin
        // SETHEX, SETDEC
        o_class          = SET_MODE;
        o_flags.mode_dec = i_nibble[0];
      end
      4'h6, 4'h7: begin
        // RSTK=C pushes, C=RSTK pops
        o_op         = COPY;
        o_flags.push = !i_nibble[0];
        o_flags.pop  = i_nibble[0];
      end
      4'h8: begin
        o_op = ZERO;
      end
      4'h9, 4'hA: begin
        o_op = COPY;
      end
      4'hB: begin
        o_op = EXCH;
      end
      4'hC, 4'hD: begin
        // P=P+1, P=P-1
        o_op = i_nibble[0] ? DEC : INC;
      end
      default: begin
        o_class = ERROR;
      end
    endcase
  end

endmodule

/* hw/dec_sequencer.sv */
// decode sequencer
`timescale 1ns/100ps

module dec_sequencer
  import saturn_dec_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic             i_en_dec,
  input  logic             i_stall,
  input  nib_in_t          i_nib,
  input  first_dec_t       i_first,
  input  ins_class_e       i_blk0_class,
  input  alu_op_e          i_blk0_op,
  input  dec_flags_t       i_blk0_flags,
  input  logic [IMM_W-1:0] i_imm,
  input  logic             i_imm_last,
  output logic             o_imm_start,
  output logic             o_imm_take,
  output logic             o_imm_count,
  output logic [LEN_W-1:0] o_imm_len,
  output ins_rec_t         o_ins,
  output logic             o_ins_valid
);

  dec_state_e        state_q;
  dec_state_e        state_d;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  cnt_q;
  ins_class_e        cls_q;
  alu_op_e           op_q;
  dec_flags_t        flags_q;
  logic              consume;
  logic              done;
  ins_rec_t          rec_d;

  // a nibble moves only when enabled and not stalled
  assign consume = i_en_dec && !i_stall;

  // jumps start the collector on the opcode, 3n on its count nibble
  assign o_imm_start = consume &&
                       ((state_q == FIRST && i_first.next_state == IMM) ||
                        (state_q == IMM_FIRST && cls_q == LOAD_C));
  assign o_imm_count = (state_q == IMM_FIRST);
  assign o_imm_len   = i_first.imm_len;
  assign o_imm_take  = consume && (state_q == IMM);

  always_comb begin
    state_d         = state_q;
    done            = 1'b0;
    rec_d.addr      = addr_q;
    rec_d.ins_class = cls_q;
    rec_d.alu_op    = op_q;
    rec_d.flags     = flags_q;
    rec_d.imm       = '0;
    rec_d.nib_cnt   = cnt_q + 1'b1;

    case (state_q)
      FIRST: begin
        // errors end here, everything else moves on
        state_d         = i_first.next_state;
        done            = (i_first.next_state == FIRST);
        rec_d.addr      = i_nib.pc;
        rec_d.ins_class = i_first.ins_class;
        rec_d.alu_op    = i_first.alu_op;
        rec_d.flags     = i_first.flags;
        rec_d.nib_cnt   = LEN_W'(1);
      end
      BLOCK0: begin
        state_d         = FIRST;
        done            = 1'b1;
        rec_d.ins_class = i_blk0_class;
        rec_d.alu_op    = i_blk0_op;
        rec_d.flags     = i_blk0_flags;
      end
      IMM_FIRST: begin
        if (cls_q == LOAD_P) begin
          // P=n carries n itself
          state_d   = FIRST;
          done      = 1'b1;
          rec_d.imm = IMM_W'(i_nib.nibble);
        end else begin
          state_d = IMM;
        end
      end
      IMM: begin
        done      = i_imm_last;
        rec_d.imm = i_imm;
        if (i_imm_last) begin
          state_d = FIRST;
        end
      end
      default: begin
        state_d = FIRST;
      end
    endcase
  end

  // control state
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q     <= FIRST;
      cnt_q       <= '0;
      o_ins_valid <= 1'b0;
    end else begin
      o_ins_valid <= consume && done;
      if (consume) begin
        state_q <= state_d;
        cnt_q   <= rec_d.nib_cnt;
      end
    end
  end

  // instruction context from the first nibble
  always_ff @(posedge i_clk) begin
    if (consume && state_q == FIRST) begin
      addr_q  <= i_nib.pc;
      cls_q   <= i_first.ins_class;
      op_q    <= i_first.alu_op;
      flags_q <= i_first.flags;
    end
  end

  // record held until the next one completes
  always_ff @(posedge i_clk) begin
    if (consume && done) begin
      o_ins <= rec_d;
    end
  end

endmodule

/* hw/first_nibble_decode.sv */
// first nibble decoder
`timescale 1ns/100ps

module first_nibble_decode
  import saturn_dec_pkg::*;
(
  input  logic [NIB_W-1:0] i_nibble,
  output first_dec_t       o_dec
);

  always_comb begin
    // unhandled first nibbles end as errors
    o_dec.next_state = FIRST;
    o_dec.ins_class  = ERROR;
    o_dec.alu_op     = NONE;
    o_dec.flags      = '0;
    o_dec.imm_len    = '0;

    case (i_nibble)
      4'h0: begin
        // class comes from the second nibble
        o_dec.next_state = BLOCK0;
      end
      4'h2, 4'h3: begin
        // 2n P=n, 3n load constant into C
        o_dec.next_state = IMM_FIRST;
        o_dec.ins_class  = i_nibble[0] ? LOAD_C : LOAD_P;
        o_dec.alu_op     = COPY;
      end
      4'h4, 4'h5: begin
        // 4xy GOC, 5xy GONC
        o_dec.next_state       = IMM;
        o_dec.ins_class        = JUMP;
        o_dec.alu_op           = JMP_REL2;
        o_dec.flags.test_carry = 1'b1;
        o_dec.flags.carry_val  = !i_nibble[0];
        o_dec.imm_len          = LEN_W'(2);
      end
      4'h6, 4'h7: begin
        // 6xxx GOTO, 7xxx GOSUB
        o_dec.next_state = IMM;
        o_dec.ins_class  = JUMP;
        o_dec.alu_op     = JMP_REL3;
        o_dec.flags.push = i_nibble[0];
        o_dec.imm_len    = LEN_W'(3);
      end
      default: begin
        o_dec.next_state = FIRST;
      end
    endcase
  end

endmodule

/* hw/imm_collector.sv */
// immediate nibble collector
`timescale 1ns/100ps

module imm_collector
  import saturn_dec_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic             i_start,
  input  logic             i_take,
  input  logic [LEN_W-1:0] i_len,
  input  logic [NIB_W-1:0] i_nibble,
  input  logic             i_count_mode,
  output logic [IMM_W-1:0] o_imm,
  output logic             o_last
);

  logic [IMM_W-1:0] imm_q;
  logic [LEN_W-1:0] pos_q;
  logic [LEN_W-1:0] len_q;
  logic [IMM_W-1:0] nib_shift;

  // first nibble taken lands in the low bits
  assign nib_shift = IMM_W'(i_nibble) << (pos_q * NIB_W);

  // nibble being taken is already visible in the value
  assign o_imm  = i_take ? (imm_q | nib_shift) : imm_q;
  assign o_last = i_take && ((pos_q + 1'b1) == len_q);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pos_q <= '0;
      len_q <= '0;
    end else if (i_start) begin
      pos_q <= '0;
      // 3n loads n+1 nibbles
      len_q <= i_count_mode ? (LEN_W'(i_nibble) + 1'b1) : i_len;
    end else if (i_take) begin
      pos_q <= pos_q + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      imm_q <= '0;
    end else if (i_take) begin
      imm_q <= o_imm;
    end
  end

endmodule

/* hw/saturn_dec_pkg.sv */
// saturn decoder shared types
package saturn_dec_pkg;

  // widths
  localparam int ADDR_W   = 20;
  localparam int NIB_W    = 4;
  localparam int IMM_NIBS = 16;
  localparam int IMM_W    = IMM_NIBS * NIB_W;
  localparam int LEN_W    = 5;

  // sequencer state, IMM_FIRST is the nibble after a 2 or a 3
  typedef enum logic [1:0] {
    FIRST     = 2'd0,
    BLOCK0    = 2'd1,
    IMM_FIRST = 2'd2,
    IMM       = 2'd3
  } dec_state_e;

  typedef enum logic [2:0] {
    RTN      = 3'd0,
    SET_MODE = 3'd1,
    ALU      = 3'd2,
    LOAD_P   = 3'd3,
    LOAD_C   = 3'd4,
    JUMP     = 3'd5,
    ERROR    = 3'd6
  } ins_class_e;

  typedef enum logic [3:0] {
    NONE     = 4'd0,
    COPY     = 4'd1,
    EXCH     = 4'd2,
    ZERO     = 4'd3,
    INC      = 4'd4,
    DEC      = 4'd5,
    JMP_REL2 = 4'd6,
    JMP_REL3 = 4'd7
  } alu_op_e;

  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [NIB_W-1:0]  nibble;
  } nib_in_t;

  // push sits in the msb of the flags byte
  typedef struct packed {
    logic push;
    logic pop;
    logic set_xm;
    logic set_carry;
    logic test_carry;
    logic carry_val;
    logic en_intr;
    logic mode_dec;
  } dec_flags_t;

  typedef struct packed {
    dec_state_e       next_state;
    ins_class_e       ins_class;
    alu_op_e          alu_op;
    dec_flags_t       flags;
    logic [LEN_W-1:0] imm_len;
  } first_dec_t;

  // one decoded instruction
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    ins_class_e        ins_class;
    alu_op_e           alu_op;
    dec_flags_t        flags;
    logic [IMM_W-1:0]  imm;
    logic [LEN_W-1:0]  nib_cnt;
  } ins_rec_t;

endpackage

/* hw/saturn_dec_top.sv */
// saturn instruction decoder
`timescale 1ns/100ps

module saturn_dec_top
  import saturn_dec_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset,
  input  logic     i_en_dec,
  input  logic     i_stall,
  input  nib_in_t  i_nib,
  output ins_rec_t o_ins,
  output logic     o_ins_valid
);

  first_dec_t       first_dec;
  ins_class_e       blk0_class;
  alu_op_e          blk0_op;
  dec_flags_t       blk0_flags;
  logic [IMM_W-1:0] imm;
  logic             imm_last;
  logic             imm_start;
  logic             imm_take;
  logic             imm_count;
  logic [LEN_W-1:0] imm_len;

  dec_sequencer dec_sequencer_inst (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_en_dec     (i_en_dec),
    .i_stall      (i_stall),
    .i_nib        (i_nib),
    .i_first      (first_dec),
    .i_blk0_class (blk0_class),
    .i_blk0_op    (blk0_op),
    .i_blk0_flags (blk0_flags),
    .i_imm        (imm),
    .i_imm_last   (imm_last),
    .o_imm_start  (imm_start),
    .o_imm_take   (imm_take),
    .o_imm_count  (imm_count),
    .o_imm_len    (imm_len),
    .o_ins        (o_ins),
    .o_ins_valid  (o_ins_valid)
  );

  first_nibble_decode first_nibble_decode_inst (
    .i_nibble (i_nib.nibble),
    .o_dec    (first_dec)
  );

  block0_decode block0_decode_inst (
    .i_nibble (i_nib.nibble),
    .o_class  (blk0_class),
    .o_op     (blk0_op),
    .o_flags  (blk0_flags)
  );

  imm_collector imm_collector_inst (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_start      (imm_start),
    .i_take       (imm_take),
    .i_len        (imm_len),
    .i_nibble     (i_nib.nibble),
    .i_count_mode (imm_count),
    .o_imm        (imm),
    .o_last       (imm_last)
  );

endmodule

/* project.f */
hw/saturn_dec_pkg.sv
hw/first_nibble_decode.sv
hw/block0_decode.sv
hw/imm_collector.sv
hw/dec_sequencer.sv
hw/saturn_dec_top.sv
dv/tb_clock_gen.sv
dv/tb_saturn_dec.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decoder testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_saturn_dec
LOG=sim.log

verilator --binary --timing --top-module "$TOP" -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
